/* Makefile */
VERILATOR := verilator
TOP       := tb_dac_spi
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
rtl/dac_pkg.sv
rtl/frame_fifo.sv
rtl/dac_frame_builder.sv
rtl/spi_frame_tx.sv
rtl/dac_frame_rx.sv
rtl/dac_spi_top.sv
sim/tb_dac_spi.sv

/* rtl/dac_frame_builder.sv */
`timescale 1ns/1ps

module dac_frame_builder
   import dac_pkg::*;
(
   input  logic         DAC_CS,
   input  logic         rst_n,
   input  logic         req_valid,
   input  dac_request_t req,
   input  logic         fifo_full,
   output logic         push,
   output dac_frame_t   frame,
   output logic         busy
);

   // Channels still waiting for their frame
   logic [N_CHANNELS-1:0] mask_q;
   logic [N_CHANNELS-1:0] mask_next;
   // Code of the request being served
   dac_value_t value_q;
   // Full mask goes out as one broadcast frame
   logic broadcast_q;
   logic active_q;
   dac_addr_t addr;
   logic last;

   // Address of the lowest pending channel
   function automatic dac_addr_t lowest_addr(input logic [N_CHANNELS-1:0] m);
      dac_addr_t a;
      a = '0;
      // Scan downwards so the lowest set bit wins
      for (int i = N_CHANNELS - 1; i >= 0; i--) begin
         if (m[i]) begin
            a = dac_addr_t'(i);
         end
      end
      return a;
   endfunction

   // Drop the lowest set bit once its frame is pushed
   assign mask_next = mask_q & (mask_q - {{(N_CHANNELS-1){1'b0}}, 1'b1});
   assign addr = broadcast_q ? ADDR_ALL : lowest_addr(mask_q);
   // Broadcast is always a single frame
   assign last = broadcast_q || (mask_next == '0);

   // One frame per cycle unless the FIFO is full
   assign push = active_q && !fifo_full;
   assign busy = active_q;

   // Don't-care fields go out as zeros
   assign frame = '{lead: '0, command: CMD_WRITE_UPDATE, address: addr,
                    value: value_q, tail: '0};

   always_ff @(posedge DAC_CS or negedge rst_n) begin
      if (!rst_n) begin
         active_q    <= 1'b0;
         mask_q      <= '0;
         broadcast_q <= 1'b0;
      end else if (!active_q) begin
         // Empty mask is ignored
         if (req_valid && (req.chan_mask != '0)) begin
            active_q    <= 1'b1;
            mask_q      <= req.chan_mask;
            broadcast_q <= &req.chan_mask;
         end
      end else if (push) begin
         mask_q <= mask_next;
         if (last) begin
            active_q <= 1'b0;
         end
      end
   end

   // Value latched with the request
   always_ff @(posedge DAC_CS) begin
      if (req_valid && !active_q) begin
         value_q <= req.value;
      end
   end

   // Stalled frame waits unchanged until the FIFO has room
   a_hold_when_full: assert property (@(posedge DAC_CS) disable iff (!rst_n)
      (busy && fifo_full) |=> (busy && $stable(frame)));

endmodule

/* rtl/dac_frame_rx.sv */
`timescale 1ns/1ps

module dac_frame_rx
   import dac_pkg::*;
(
   input  logic          DAC_CS,
   input  logic          rst_n,
   input  logic          dac_sck,
   input  logic          dac_cs_n,
   input  logic          dac_mosi,
   input  logic          dac_clr_n,
   output dac_channels_t channels,
   output rx_status_t    status,
   output logic          frame_done
);

   // Bus pins sampled together
   typedef struct packed {
      logic sck;
      logic cs_n;
      logic mosi;
      logic clr_n;
   } bus_t;

   // Idle levels of the pins
   localparam bus_t BUS_IDLE = '{sck: 1'b0, cs_n: 1'b1, mosi: 1'b0, clr_n: 1'b1};
   // Bit count saturates one past a full frame
   localparam int CNT_BITS = $clog2(FRAME_BITS + 2);
   localparam int CLR_BITS = $clog2(CLR_MIN_CYCLES + 1);

   // Two synchronizing stages, then the previous value for edges
   bus_t meta_q;
   bus_t sync_q;
   bus_t prev_q;

   logic sck_rise;
   logic cs_rise;
   logic cs_fall;
   logic clr_rise;
   logic clr_valid;

   logic [CNT_BITS-1:0] bit_cnt_q;
   logic [FRAME_BITS-1:0] rx_shift_q;
   dac_frame_t rx_frame;

   // Length of the current clear pulse
   logic [CLR_BITS-1:0] clr_cnt_q;
   logic cleared_q;

   logic count_ok;
   logic addr_all;
   logic addr_ok;
   logic cmd_ok;
   logic write_en;

   always_ff @(posedge DAC_CS or negedge rst_n) begin
      if (!rst_n) begin
         meta_q <= BUS_IDLE;
         sync_q <= BUS_IDLE;
         prev_q <= BUS_IDLE;
      end else begin
         meta_q <= '{sck: dac_sck, cs_n: dac_cs_n, mosi: dac_mosi, clr_n: dac_clr_n};
         sync_q <= meta_q;
         prev_q <= sync_q;
      end
   end

   // Edges in the system clock domain
   // sck only counts inside a chip-select window
   assign sck_rise = sync_q.sck & ~prev_q.sck & ~sync_q.cs_n;
   assign cs_rise  = sync_q.cs_n & ~prev_q.cs_n;
   assign cs_fall  = ~sync_q.cs_n & prev_q.cs_n;
   assign clr_rise = sync_q.clr_n & ~prev_q.clr_n;

   // Clear counts only if it stayed low long enough
   assign clr_valid = clr_rise && (clr_cnt_q == CLR_BITS'(CLR_MIN_CYCLES));

   always_ff @(posedge DAC_CS or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt_q <= '0;
      end else if (cs_fall) begin
         bit_cnt_q <= '0;
      end else if (sck_rise && (bit_cnt_q != CNT_BITS'(FRAME_BITS + 1))) begin
         bit_cnt_q <= bit_cnt_q + CNT_BITS'(1);
      end
   end

   // Shift in MSB first, last 32 bits are kept
   always_ff @(posedge DAC_CS) begin
      if (sck_rise) begin
         rx_shift_q <= {rx_shift_q[FRAME_BITS-2:0], sync_q.mosi};
      end
   end

   assign rx_frame = rx_shift_q;

   always_ff @(posedge DAC_CS or negedge rst_n) begin
      if (!rst_n) begin
         clr_cnt_q <= '0;
         cleared_q <= 1'b0;
      end else begin
         // Measure low time, saturating at the minimum
         if (sync_q.clr_n) begin
            clr_cnt_q <= '0;
         end else if (clr_cnt_q != CLR_BITS'(CLR_MIN_CYCLES)) begin
            clr_cnt_q <= clr_cnt_q + CLR_BITS'(1);
         end
         if (clr_valid) begin
            cleared_q <= 1'b1;
         end
      end
   end

   // Frame checks
   assign count_ok = (bit_cnt_q == CNT_BITS'(FRAME_BITS));
   assign addr_all = (rx_frame.address == ADDR_ALL);
   assign addr_ok  = addr_all || (rx_frame.address < dac_addr_t'(N_CHANNELS));
   assign cmd_ok   = (rx_frame.command == CMD_WRITE_UPDATE);
   assign write_en = cs_rise && cleared_q && count_ok && addr_ok && cmd_ok;

   always_ff @(posedge DAC_CS or negedge rst_n) begin
      if (!rst_n) begin
         frame_done <= 1'b0;
         status     <= '0;
      end else begin
         frame_done <= cs_rise;
         if (cs_rise) begin
            // Uncleared device ignores the frame
            if (!cleared_q) begin
               status.not_cleared <= 1'b1;
            end else if (!count_ok) begin
               // Fields are meaningless with a wrong count
               status.bad_count <= 1'b1;
            end else begin
               if (!addr_ok) begin
                  status.bad_address <= 1'b1;
               end
               if (!cmd_ok) begin
                  status.bad_command <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge DAC_CS or negedge rst_n) begin
      if (!rst_n) begin
         channels <= '0;
      end else if (clr_valid) begin
         channels <= '0;
      end else if (write_en) begin
         // Broadcast hits every channel
         for (int i = 0; i < N_CHANNELS; i++) begin
            if (addr_all || (rx_frame.address == dac_addr_t'(i))) begin
               channels[i] <= rx_frame.value;
            end
         end
      end
   end

   // Verdict only after the pin-level window closed, three cycles back
   a_judge_after_window: assert property (@(posedge DAC_CS) disable iff (!rst_n)
      frame_done |-> $past(dac_cs_n, 3));

endmodule

/* rtl/dac_pkg.sv */
package dac_pkg;

   // Frame and channel geometry
   localparam int FRAME_BITS = 32;
   localparam int VALUE_BITS = 12;
   localparam int N_CHANNELS = 4;

   // System clock cycles per half period of sck
   localparam int SCK_HALF = 2;

   // Frames buffered between builder and transmitter
   localparam int FIFO_DEPTH = 8;

   // Shortest clear pulse taken as a device reset
   localparam int CLR_MIN_CYCLES = 10;

   // DAC code and the two 4-bit frame fields
   typedef logic [VALUE_BITS-1:0] dac_value_t;
   typedef logic [3:0] dac_cmd_t;
   typedef logic [3:0] dac_addr_t;

   // Write to input register and update output, the only command accepted
   localparam dac_cmd_t CMD_WRITE_UPDATE = 4'b0011;
   // Address that selects all four channels at once
   localparam dac_addr_t ADDR_ALL = 4'b1111;

   // One frame, first field goes out first, each field MSB first
   typedef struct packed {
      logic [7:0] lead;
      dac_cmd_t   command;
      dac_addr_t  address;
      dac_value_t value;
      logic [3:0] tail;
   } dac_frame_t;

   // Host request, one mask bit per channel A to D
   typedef struct packed {
      logic [N_CHANNELS-1:0] chan_mask;
      dac_value_t            value;
   } dac_request_t;

   // Sticky receiver error flags
   typedef struct packed {
      logic not_cleared;
      logic bad_count;
      logic bad_address;
      logic bad_command;
   } rx_status_t;

   // Channel registers, A at index 0
   typedef dac_value_t [N_CHANNELS-1:0] dac_channels_t;

endpackage

/* rtl/dac_spi_top.sv */
`timescale 1ns/1ps

module dac_spi_top
   import dac_pkg::*;
(
   input  logic          DAC_CS,
   input  logic          rst_n,
   input  logic          req_valid,
   input  dac_request_t  req,
   input  logic          dac_sck,
   input  logic          dac_cs_n,
   input  logic          dac_mosi,
   input  logic          dac_clr_n,
   output logic          busy,
   output logic          spi_sck,
   output logic          spi_mosi,
   output logic          spi_cs_n,
   output dac_channels_t channels,
   output rx_status_t    status,
   output logic          frame_done
);

   // Builder to FIFO
   logic       fifo_push;
   dac_frame_t push_frame;
   logic       fifo_full;

   // FIFO to transmitter
   logic       fifo_pop;
   logic       fifo_not_empty;
   dac_frame_t head_frame;

   // Requests become frames
   dac_frame_builder u_dac_frame_builder (
      .DAC_CS    (DAC_CS),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .fifo_full (fifo_full),
      .push      (fifo_push),
      .frame     (push_frame),
      .busy      (busy)
   );

   frame_fifo #(
      .payload_t (dac_frame_t),
      .depth     (FIFO_DEPTH)
   ) u_frame_fifo (
      .DAC_CS    (DAC_CS),
      .rst_n     (rst_n),
      .push      (fifo_push),
      .push_data (push_frame),
      .pop       (fifo_pop),
      .head      (head_frame),
      .not_empty (fifo_not_empty),
      .full      (fifo_full)
   );

   // Controller bus pins
   spi_frame_tx u_spi_frame_tx (
      .DAC_CS    (DAC_CS),
      .rst_n     (rst_n),
      .not_empty (fifo_not_empty),
      .head      (head_frame),
      .pop       (fifo_pop),
      .spi_sck   (spi_sck),
      .spi_mosi  (spi_mosi),
      .spi_cs_n  (spi_cs_n)
   );

   // DAC model on its own input pins
   dac_frame_rx u_dac_frame_rx (
      .DAC_CS     (DAC_CS),
      .rst_n      (rst_n),
      .dac_sck    (dac_sck),
      .dac_cs_n   (dac_cs_n),
      .dac_mosi   (dac_mosi),
      .dac_clr_n  (dac_clr_n),
      .channels   (channels),
      .status     (status),
      .frame_done (frame_done)
   );

endmodule

/* rtl/frame_fifo.sv */
`timescale 1ns/1ps

module frame_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 4
) (
   input  logic     DAC_CS,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     not_empty,
   output logic     full
);

   // Pointer and occupancy widths
   localparam int PTR_BITS = (depth > 1) ? $clog2(depth) : 1;
   localparam int CNT_BITS = $clog2(depth + 1);

   // Storage
   payload_t mem [depth];

   logic [PTR_BITS-1:0] wr_ptr_q;
   logic [PTR_BITS-1:0] rd_ptr_q;
   logic [CNT_BITS-1:0] count_q;

   // Wrap at depth, which need not be a power of two
   function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
      if (p == PTR_BITS'(depth - 1)) begin
         return '0;
      end
      return p + PTR_BITS'(1);
   endfunction

   always_ff @(posedge DAC_CS or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         // Simultaneous push and pop keeps the count
         case ({push, pop})
            2'b10:   count_q <= count_q + CNT_BITS'(1);
            2'b01:   count_q <= count_q - CNT_BITS'(1);
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge DAC_CS) begin
      if (push) begin
         mem[wr_ptr_q] <= push_data;
      end
   end

   // Head visible the cycle after the first write
   assign head      = mem[rd_ptr_q];
   assign not_empty = (count_q != '0);
   assign full      = (count_q == CNT_BITS'(depth));

   // Writer respects full
   a_no_overflow: assert property (@(posedge DAC_CS) disable iff (!rst_n)
      push |-> !full);
   // Reader respects empty
   a_no_underflow: assert property (@(posedge DAC_CS) disable iff (!rst_n)
      pop |-> not_empty);

endmodule

/* rtl/spi_frame_tx.sv */
`timescale 1ns/1ps

module spi_frame_tx
   import dac_pkg::*;
(
   input  logic       DAC_CS,
   input  logic       rst_n,
   input  logic       not_empty,
   input  dac_frame_t head,
   output logic       pop,
   output logic       spi_sck,
   output logic       spi_mosi,
   output logic       spi_cs_n
);

   // Half-period divider and bit counter widths
   localparam int DIV_BITS = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
   localparam int CNT_BITS = $clog2(FRAME_BITS);

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_SHIFT,
      TX_GAP
   } tx_state_t;

   tx_state_t state_q;
   // Frame being sent, MSB on the wire
   logic [FRAME_BITS-1:0] shift_q;
   logic [DIV_BITS-1:0] div_q;
   // Bits sent in shift, idle cycles in gap
   logic [CNT_BITS-1:0] bit_cnt_q;
   logic sck_q;
   logic cs_n_q;
   logic half_end;

   // Take a frame only between frames
   assign pop = (state_q == TX_IDLE) && not_empty;
   assign half_end = (div_q == DIV_BITS'(SCK_HALF - 1));

   assign spi_sck  = sck_q;
   assign spi_cs_n = cs_n_q;
   assign spi_mosi = shift_q[FRAME_BITS-1];

   always_ff @(posedge DAC_CS or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= TX_IDLE;
         shift_q   <= '0;
         div_q     <= '0;
         bit_cnt_q <= '0;
         sck_q     <= 1'b0;
         cs_n_q    <= 1'b1;
      end else begin
         case (state_q)
            TX_IDLE: begin
               // Chip select falls with the first bit already on mosi
               if (pop) begin
                  state_q   <= TX_SHIFT;
                  shift_q   <= head;
                  div_q     <= '0;
                  bit_cnt_q <= '0;
                  sck_q     <= 1'b0;
                  cs_n_q    <= 1'b0;
               end
            end
            TX_SHIFT: begin
               if (half_end) begin
                  div_q <= '0;
                  sck_q <= ~sck_q;
                  // Falling edge moves to the next bit
                  if (sck_q) begin
                     shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
                     if (bit_cnt_q == CNT_BITS'(FRAME_BITS - 1)) begin
                        state_q   <= TX_GAP;
                        bit_cnt_q <= '0;
                     end else begin
                        bit_cnt_q <= bit_cnt_q + CNT_BITS'(1);
                     end
                  end
               end else begin
                  div_q <= div_q + DIV_BITS'(1);
               end
            end
            TX_GAP: begin
               // cs_n rises one cycle after the last falling edge
               cs_n_q    <= 1'b1;
               bit_cnt_q <= bit_cnt_q + CNT_BITS'(1);
               // Keep cs_n high a full sck period before the next frame
               if (bit_cnt_q == CNT_BITS'(2 * SCK_HALF)) begin
                  state_q <= TX_IDLE;
               end
            end
            default: begin
               state_q <= TX_IDLE;
            end
         endcase
      end
   end

   // Data only moves on falling edges
   a_mosi_stable: assert property (@(posedge DAC_CS) disable iff (!rst_n)
      (!spi_cs_n && spi_sck && $past(spi_sck)) |-> $stable(spi_mosi));

endmodule

/* sim/tb_dac_spi.sv */
`timescale 1ns/1ps

module tb_dac_spi
   import dac_pkg::*;
();

   // Cycles from pop to chip select rising
   localparam int FRAME_CYCLES = 130;
   // Frames in all tests, 2 + 4 + 3 + 16 + 3
   localparam int TOTAL_FRAMES = 28;
   localparam int CYCLE_LIMIT  = FRAME_CYCLES * TOTAL_FRAMES + 500;
   // Longest wait for a single verdict
   localparam int DONE_TIMEOUT = 3 * FRAME_CYCLES;

   logic          DAC_CS;
   logic          rst_n;
   logic          req_valid;
   dac_request_t  req;
   logic          busy;
   logic          spi_sck;
   logic          spi_mosi;
   logic          spi_cs_n;
   dac_channels_t channels;
   rx_status_t    status;
   logic          frame_done;

   // Pins of the DAC model
   logic dac_sck;
   logic dac_cs_n;
   logic dac_mosi;
   logic dac_clr_n;
   // Forced bus for malformed frames
   logic drv_sck;
   logic drv_cs_n;
   logic drv_mosi;
   logic loopback;

   // Reference state of the DAC
   dac_channels_t exp_channels;
   rx_status_t    exp_status;
   logic          exp_cleared;
   // Frames still to be judged, oldest first
   dac_frame_t    exp_q [$];

   int errors;
   int cycle_count;
   integer seed;

   assign dac_sck  = loopback ? spi_sck  : drv_sck;
   assign dac_cs_n = loopback ? spi_cs_n : drv_cs_n;
   assign dac_mosi = loopback ? spi_mosi : drv_mosi;

   dac_spi_top u_dac_spi_top (
      .DAC_CS     (DAC_CS),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .dac_sck    (dac_sck),
      .dac_cs_n   (dac_cs_n),
      .dac_mosi   (dac_mosi),
      .dac_clr_n  (dac_clr_n),
      .busy       (busy),
      .spi_sck    (spi_sck),
      .spi_mosi   (spi_mosi),
      .spi_cs_n   (spi_cs_n),
      .channels   (channels),
      .status     (status),
      .frame_done (frame_done)
   );

   initial begin
      DAC_CS = 1'b0;
      forever #2 DAC_CS = ~DAC_CS;
   end

   // Watchdog over the whole run
   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge DAC_CS);
         cycle_count++;
      end
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors: %0d", errors);
      $display("test failed");
      $finish;
   end

   // Next drive and sample point, 1 ns after the edge
   task automatic tick();
      @(posedge DAC_CS);
      #1;
   endtask

   function automatic dac_value_t rand_value();
      return dac_value_t'($random(seed));
   endfunction

   task automatic check_channels(input dac_channels_t got, input dac_channels_t exp,
                                 input string what);
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: %s channels %h expected %h", $time, what, got, exp);
      end
   endtask

   // Flags in order not_cleared, bad_count, bad_address, bad_command
   task automatic check_status(input rx_status_t got, input rx_status_t exp,
                               input string what);
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: %s status %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: %s is %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic wait_done(input string what);
      int n;
      n = 0;
      do begin
         tick();
         n++;
      end while (frame_done !== 1'b1 && n < DONE_TIMEOUT);
      if (frame_done !== 1'b1) begin
         errors++;
         $display("No frame_done within %0d cycles during %s", DONE_TIMEOUT, what);
      end
   endtask

   // What the DAC does with one received window
   task automatic judge_frame(input dac_frame_t f, input int nbits);
      logic all;
      logic addr_ok;
      logic cmd_ok;
      all     = (f.address == ADDR_ALL);
      addr_ok = all || (f.address < dac_addr_t'(N_CHANNELS));
      cmd_ok  = (f.command == CMD_WRITE_UPDATE);
      if (!exp_cleared) begin
         exp_status.not_cleared = 1'b1;
      end else if (nbits != FRAME_BITS) begin
         exp_status.bad_count = 1'b1;
      end else begin
         if (!addr_ok) begin
            exp_status.bad_address = 1'b1;
         end
         if (!cmd_ok) begin
            exp_status.bad_command = 1'b1;
         end
         if (addr_ok && cmd_ok) begin
            for (int i = 0; i < N_CHANNELS; i++) begin
               if (all || f.address == dac_addr_t'(i)) begin
                  exp_channels[i] = f.value;
               end
            end
         end
      end
   endtask

   // Full mask is one broadcast, else one frame per bit from channel A up
   task automatic expect_frames(input dac_request_t r);
      dac_frame_t f;
      f = '{lead: '0, command: CMD_WRITE_UPDATE, address: ADDR_ALL, value: r.value, tail: '0};
      if (&r.chan_mask) begin
         exp_q.push_back(f);
      end else begin
         for (int i = 0; i < N_CHANNELS; i++) begin
            if (r.chan_mask[i]) begin
               f.address = dac_addr_t'(i);
               exp_q.push_back(f);
            end
         end
      end
   endtask

   // Host strobe, only while the builder is idle
   task automatic issue_request(input logic [N_CHANNELS-1:0] mask, input dac_value_t code);
      while (busy) begin
         tick();
      end
      req_valid = 1'b1;
      req       = '{chan_mask: mask, value: code};
      expect_frames(req);
      tick();
      req_valid = 1'b0;
   endtask

   task automatic check_next_frame(input string what);
      dac_frame_t f;
      wait_done(what);
      if (exp_q.size() == 0) begin
         errors++;
         $display("Unexpected frame_done during %s", what);
      end else begin
         f = exp_q.pop_front();
         judge_frame(f, FRAME_BITS);
      end
      check_channels(channels, exp_channels, what);
      check_status(status, exp_status, what);
   endtask

   task automatic pulse_clear(input int low_cycles);
      dac_clr_n = 1'b0;
      repeat (low_cycles) tick();
      dac_clr_n = 1'b1;
      // Let the rising edge pass the synchronizer
      repeat (6) tick();
      if (low_cycles >= CLR_MIN_CYCLES) begin
         exp_cleared  = 1'b1;
         exp_channels = '0;
      end
      check_channels(channels, exp_channels, "clear pulse");
   endtask

   // Window on the forced bus, MSB first, data set while sck is low
   task automatic drive_raw_frame(input dac_frame_t f, input int nbits);
      logic [FRAME_BITS-1:0] bits;
      bits     = f;
      drv_cs_n = 1'b0;
      for (int i = 0; i < nbits; i++) begin
         drv_mosi = bits[FRAME_BITS-1-i];
         repeat (SCK_HALF) tick();
         drv_sck = 1'b1;
         repeat (SCK_HALF) tick();
         drv_sck = 1'b0;
      end
      tick();
      drv_cs_n = 1'b1;
      drv_mosi = 1'b0;
   endtask

   task automatic forced_frame(input dac_frame_t f, input int nbits, input string what);
      drive_raw_frame(f, nbits);
      wait_done(what);
      judge_frame(f, nbits);
      check_channels(channels, exp_channels, what);
      check_status(status, exp_status, what);
   endtask

   task automatic check_reset_state();
      check_bit(busy, 1'b0, "busy after reset");
      check_bit(spi_cs_n, 1'b1, "spi_cs_n after reset");
      check_bit(spi_sck, 1'b0, "spi_sck after reset");
      check_bit(frame_done, 1'b0, "frame_done after reset");
      check_channels(channels, exp_channels, "after reset");
      check_status(status, exp_status, "after reset");
   endtask

   // Uncleared DAC drops frames, a short clear is not enough
   task automatic test_before_clear();
      issue_request(4'b0001, rand_value());
      check_next_frame("frame before clear");
      pulse_clear(CLR_MIN_CYCLES - 4);
      issue_request(4'b0010, rand_value());
      check_next_frame("frame after short clear");
      pulse_clear(CLR_MIN_CYCLES + 2);
   endtask

   task automatic test_single_channels();
      logic [N_CHANNELS-1:0] mask;
      for (int i = 0; i < N_CHANNELS; i++) begin
         mask    = '0;
         mask[i] = 1'b1;
         issue_request(mask, rand_value());
         check_next_frame($sformatf("single channel %0d", i));
      end
   endtask

   task automatic test_multi_broadcast();
      issue_request(4'b0101, rand_value());
      check_next_frame("mask A and C first");
      check_next_frame("mask A and C second");
      issue_request(4'b1111, rand_value());
      check_next_frame("broadcast");
      // A second frame would pull cs_n low within the gap
      repeat (20) begin
         tick();
         check_bit(frame_done, 1'b0, "frame_done after broadcast");
         check_bit(spi_cs_n, 1'b1, "spi_cs_n after broadcast");
      end
      // Minimum-length clear zeroes the channels just written
      pulse_clear(CLR_MIN_CYCLES);
   endtask

   // Sixteen frames against eight FIFO entries
   task automatic test_back_pressure();
      logic [N_CHANNELS-1:0] masks [8];
      masks = '{4'b0011, 4'b1100, 4'b0101, 4'b1010, 4'b1001, 4'b0110, 4'b0011, 4'b1100};
      fork
         begin
            for (int k = 0; k < 8; k++) begin
               issue_request(masks[k], rand_value());
            end
         end
         begin
            for (int k = 0; k < 16; k++) begin
               check_next_frame($sformatf("queued frame %0d", k));
            end
         end
      join
      if (exp_q.size() != 0) begin
         errors++;
         $display("Frames still expected after back-pressure test: %0d", exp_q.size());
      end
   endtask

   task automatic test_malformed();
      dac_frame_t f;
      loopback = 1'b0;
      tick();
      f = '{lead: '0, command: CMD_WRITE_UPDATE, address: 4'd1, value: rand_value(), tail: '0};
      forced_frame(f, FRAME_BITS - 1, "short frame");
      f.address = 4'b0101;
      forced_frame(f, FRAME_BITS, "bad address");
      f.address = 4'd2;
      f.command = ~CMD_WRITE_UPDATE;
      forced_frame(f, FRAME_BITS, "bad command");
      loopback = 1'b1;
   endtask

   initial begin
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req          = '0;
      drv_sck      = 1'b0;
      drv_cs_n     = 1'b1;
      drv_mosi     = 1'b0;
      dac_clr_n    = 1'b1;
      loopback     = 1'b1;
      errors       = 0;
      seed         = 32'h9517_090f;
      exp_channels = '0;
      exp_status   = '0;
      exp_cleared  = 1'b0;
      repeat (2) @(posedge DAC_CS);
      #1;
      rst_n = 1'b1;
      check_reset_state();
      test_before_clear();
      test_single_channels();
      test_multi_broadcast();
      test_back_pressure();
      test_malformed();
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
